//--- source/flash_ctrl_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes, latency and address rules of the flash read path, included by each RTL file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FLASH_CTRL_CFG_SVH
`define FLASH_CTRL_CFG_SVH

`define FLASH_BUS_W      32
`define FLASH_ADDR_W     16
`define FLASH_LEN_W      12
`define FLASH_WORDS      1024
// at least 2, the macro counter needs one busy cycle
`define FLASH_RD_LAT     3
`define FLASH_BAD_LO     200
`define FLASH_BAD_HI     207
`define FLASH_PROT_BASE  960
`define FLASH_FIFO_DEPTH 8

`endif

//--- source/flash_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// software-side types: error record, command opcodes and read states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package flash_ctrl_pkg;

  // packed MSB first, so err_o[3] is oob and err_o[0] is phy
  typedef struct packed {
    logic oob_err;
    logic mp_err;
    logic rd_err;
    logic phy_err;
  } flash_ctrl_err_t;

  typedef enum logic [1:0] {
    OpNop   = 2'd0,
    OpRead  = 2'd1,
    OpProg  = 2'd2,
    OpErase = 2'd3
  } cmd_op_e;

  typedef enum logic [1:0] {
    StIdle,
    StNorm,
    StErr
  } rd_state_e;

endpackage

//--- source/flash_phy_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// macro-side types and the key of the read data pattern
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package flash_phy_pkg;

  typedef enum logic {
    PhyIdle,
    PhyBusy
  } macro_state_e;

  // word data is the zero-extended address xor this key
  parameter logic [31:0] DataKey = 32'h5a3c_c3a5;

endpackage

//--- source/flash_rd_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read request and response bundle between read control and the flash macro
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "flash_ctrl_cfg.svh"

interface flash_rd_if;

  // req is held until done, done comes with data and flags
  logic                     req;
  logic [`FLASH_ADDR_W-1:0] addr;
  logic                     ovfl;
  logic [`FLASH_BUS_W-1:0]  data;
  logic                     done;
  logic                     phy_err;
  logic                     rd_err;
  logic                     mp_err;

  modport ctrl (
    output req, addr, ovfl,
    input  data, done, phy_err, rd_err, mp_err
  );

  modport phy (
    input  req, addr, ovfl,
    output data, done, phy_err, rd_err, mp_err
  );

endinterface

//--- source/flash_cmd_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command decode, accepts reads when idle and holds the request until done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "flash_ctrl_cfg.svh"

module flash_cmd_decode (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     cmd_valid_i,
  input  flash_ctrl_pkg::cmd_op_e  cmd_op_i,
  input  logic [`FLASH_ADDR_W-1:0] cmd_addr_i,
  input  logic [`FLASH_LEN_W-1:0]  cmd_len_i,
  input  logic                     op_done_i,
  output logic                     op_start_o,
  output logic [`FLASH_ADDR_W-1:0] op_addr_o,
  output logic [`FLASH_LEN_W-1:0]  op_num_words_o,
  output logic                     op_addr_oob_o,
  output logic                     cmd_rej_o,
  output logic                     busy_o
);

  logic op_start_q;
  logic cmd_rej_q;
  logic accept;

  // only a read, and only while no operation is pending
  assign accept = cmd_valid_i && (cmd_op_i == flash_ctrl_pkg::OpRead) && !op_start_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_start_q <= 1'b0;
      cmd_rej_q  <= 1'b0;
    end else begin
      cmd_rej_q <= cmd_valid_i && !accept;
      if (accept) begin
        op_start_q <= 1'b1;
      end else if (op_done_i) begin
        op_start_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_addr_o      <= cmd_addr_i;
      op_num_words_o <= cmd_len_i;
      op_addr_oob_o  <= (cmd_addr_i >= `FLASH_WORDS);
    end
  end

  assign op_start_o = op_start_q;
  assign busy_o     = op_start_q;
  assign cmd_rej_o  = cmd_rej_q;

endmodule

//--- source/flash_ctrl_rd.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read control, walks the word addresses against the macro and fills the result FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "flash_ctrl_cfg.svh"

module flash_ctrl_rd (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // operation request from decode
  input  logic                            op_start_i,
  input  logic [`FLASH_LEN_W-1:0]         op_num_words_i,
  input  logic [`FLASH_ADDR_W-1:0]        op_addr_i,
  input  logic                            op_addr_oob_i,
  output logic                            op_done_o,
  output flash_ctrl_pkg::flash_ctrl_err_t op_err_o,
  output logic [`FLASH_ADDR_W-1:0]        op_err_addr_o,

  // result FIFO
  input  logic                            data_rdy_i,
  output logic [`FLASH_BUS_W-1:0]         data_o,
  output logic                            data_wr_o,

  // flash macro
  flash_rd_if.ctrl                        flash
);

  localparam int AddrW = `FLASH_ADDR_W;
  localparam int LenW  = `FLASH_LEN_W;

  flash_ctrl_pkg::rd_state_e       st_q, st_d;
  flash_ctrl_pkg::flash_ctrl_err_t op_err_q, op_err_d;
  logic [LenW-1:0]                 cnt;
  logic                            cnt_hit;
  logic [AddrW:0]                  int_addr;
  logic                            txn_done;
  logic                            err_sel;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= flash_ctrl_pkg::StIdle;
    end else begin
      st_q <= st_d;
    end
  end

  // error record and word count restart when the operation completes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_err_q <= '0;
      cnt      <= '0;
    end else if (op_start_i && op_done_o) begin
      op_err_q <= '0;
      cnt      <= '0;
    end else begin
      op_err_q <= op_err_d;
      if (data_wr_o) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // first failing word of the operation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_err_addr_o <= '0;
    end else if (~|op_err_q && |op_err_d) begin
      op_err_addr_o <= flash.addr;
    end
  end

  assign txn_done = flash.req & flash.done;
  assign cnt_hit  = (cnt == op_num_words_i);

  // after an error the burst still runs to its length with all ones,
  // so a reader polling the FIFO is never left waiting
  always_comb begin
    st_d      = st_q;
    flash.req = 1'b0;
    data_wr_o = 1'b0;
    op_done_o = 1'b0;
    op_err_d  = op_err_q;

    unique case (st_q)
      flash_ctrl_pkg::StIdle: begin
        if (op_start_i) begin
          op_err_d.oob_err = op_addr_oob_i;
          st_d = op_addr_oob_i ? flash_ctrl_pkg::StErr : flash_ctrl_pkg::StNorm;
        end
      end

      flash_ctrl_pkg::StNorm: begin
        // no new word is requested unless the FIFO can take it
        flash.req = op_start_i & data_rdy_i;
        if (txn_done) begin
          op_err_d.mp_err  = flash.mp_err;
          op_err_d.rd_err  = flash.rd_err;
          op_err_d.phy_err = flash.phy_err;
          data_wr_o = 1'b1;
          if (cnt_hit) begin
            op_done_o = 1'b1;
            st_d = flash_ctrl_pkg::StIdle;
          end else if (|op_err_d) begin
            st_d = flash_ctrl_pkg::StErr;
          end
        end
      end

      flash_ctrl_pkg::StErr: begin
        data_wr_o = data_rdy_i;
        if (data_rdy_i && cnt_hit) begin
          op_done_o = 1'b1;
          st_d = flash_ctrl_pkg::StIdle;
        end
      end

      default: begin
        st_d = flash_ctrl_pkg::StIdle;
      end
    endcase
  end

  // extra top bit flags a walk past the end of the address space
  assign int_addr   = {1'b0, op_addr_i} + {{(AddrW - LenW + 1){1'b0}}, cnt};
  assign flash.addr = int_addr[AddrW-1:0];
  assign flash.ovfl = int_addr[AddrW];

  assign op_err_o = op_err_q | op_err_d;
  assign err_sel  = data_wr_o & |op_err_o;
  assign data_o   = err_sel ? '1 : flash.data;

endmodule

//--- source/flash_macro.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioural flash macro with fixed read latency, pattern data and address-rule errors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "flash_ctrl_cfg.svh"

module flash_macro (
  input  logic   clk_i,
  input  logic   rst_ni,
  flash_rd_if.phy phy
);

  localparam int Lat  = `FLASH_RD_LAT;
  localparam int CntW = $clog2(Lat);

  flash_phy_pkg::macro_state_e st_q;
  logic [CntW-1:0]             cnt_q;
  logic                        lat_hit;
  logic [`FLASH_ADDR_W-1:0]    addr_q;
  logic                        ovfl_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q  <= flash_phy_pkg::PhyIdle;
      cnt_q <= '0;
    end else begin
      unique case (st_q)
        flash_phy_pkg::PhyIdle: begin
          if (phy.req) begin
            st_q  <= flash_phy_pkg::PhyBusy;
            cnt_q <= CntW'(1);
          end
        end
        flash_phy_pkg::PhyBusy: begin
          if (lat_hit) begin
            st_q  <= flash_phy_pkg::PhyIdle;
            cnt_q <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          st_q <= flash_phy_pkg::PhyIdle;
        end
      endcase
    end
  end

  // address taken when the request is first seen
  always_ff @(posedge clk_i) begin
    if (st_q == flash_phy_pkg::PhyIdle && phy.req) begin
      addr_q <= phy.addr;
      ovfl_q <= phy.ovfl;
    end
  end

  assign lat_hit  = (st_q == flash_phy_pkg::PhyBusy) && (cnt_q == CntW'(Lat - 1));
  assign phy.done = lat_hit;
  assign phy.data = `FLASH_BUS_W'(addr_q) ^ flash_phy_pkg::DataKey;

  assign phy.rd_err  = lat_hit && (addr_q >= `FLASH_BAD_LO) && (addr_q <= `FLASH_BAD_HI);
  assign phy.mp_err  = lat_hit && (addr_q >= `FLASH_PROT_BASE) && (addr_q < `FLASH_WORDS);
  assign phy.phy_err = lat_hit && ((addr_q >= `FLASH_WORDS) || ovfl_q);

endmodule

//--- source/flash_rd_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// first-word-fall-through result FIFO, written by read control, popped by software
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "flash_ctrl_cfg.svh"

module flash_rd_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`FLASH_BUS_W-1:0] wdata_i,
  input  logic                    wr_i,
  input  logic                    pop_i,
  output logic                    rdy_o,
  output logic [`FLASH_BUS_W-1:0] rdata_o,
  output logic                    empty_o
);

  localparam int Depth = `FLASH_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);
  localparam int CntW  = $clog2(Depth + 1);

  logic [`FLASH_BUS_W-1:0] mem [Depth];
  logic [PtrW-1:0]         wr_ptr;
  logic [PtrW-1:0]         rd_ptr;
  logic [CntW-1:0]         count;
  logic                    do_wr;
  logic                    do_rd;

  // a write when full or a pop when empty is dropped
  assign do_wr = wr_i & rdy_o;
  assign do_rd = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PtrW'(Depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PtrW'(Depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CntW'(do_wr) - CntW'(do_rd);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  assign rdata_o = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign rdy_o   = (count != CntW'(Depth));

endmodule

//--- source/flash_ctrl_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flash read path top, command in, result words out through the FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "flash_ctrl_cfg.svh"

module flash_ctrl_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     cmd_valid_i,
  input  flash_ctrl_pkg::cmd_op_e  cmd_op_i,
  input  logic [`FLASH_ADDR_W-1:0] cmd_addr_i,
  input  logic [`FLASH_LEN_W-1:0]  cmd_len_i,
  input  logic                     pop_i,
  output logic                     cmd_rej_o,
  output logic                     busy_o,
  output logic                     done_o,
  output logic [3:0]               err_o,
  output logic [`FLASH_ADDR_W-1:0] err_addr_o,
  output logic [`FLASH_BUS_W-1:0]  rdata_o,
  output logic                     empty_o
);

  logic                            op_start;
  logic [`FLASH_ADDR_W-1:0]        op_addr;
  logic [`FLASH_LEN_W-1:0]         op_num_words;
  logic                            op_addr_oob;
  logic                            op_done;
  flash_ctrl_pkg::flash_ctrl_err_t op_err;
  logic [`FLASH_BUS_W-1:0]         fifo_data;
  logic                            fifo_wr;
  logic                            fifo_rdy;

  flash_rd_if rd_bus ();

  flash_cmd_decode u_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_op_i       (cmd_op_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_len_i      (cmd_len_i),
    .op_done_i      (op_done),
    .op_start_o     (op_start),
    .op_addr_o      (op_addr),
    .op_num_words_o (op_num_words),
    .op_addr_oob_o  (op_addr_oob),
    .cmd_rej_o      (cmd_rej_o),
    .busy_o         (busy_o)
  );

  flash_ctrl_rd u_rd (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_start_i     (op_start),
    .op_num_words_i (op_num_words),
    .op_addr_i      (op_addr),
    .op_addr_oob_i  (op_addr_oob),
    .op_done_o      (op_done),
    .op_err_o       (op_err),
    .op_err_addr_o  (err_addr_o),
    .data_rdy_i     (fifo_rdy),
    .data_o         (fifo_data),
    .data_wr_o      (fifo_wr),
    .flash          (rd_bus.ctrl)
  );

  flash_macro u_macro (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .phy    (rd_bus.phy)
  );

  flash_rd_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wdata_i (fifo_data),
    .wr_i    (fifo_wr),
    .pop_i   (pop_i),
    .rdy_o   (fifo_rdy),
    .rdata_o (rdata_o),
    .empty_o (empty_o)
  );

  // error bits are valid in the done cycle
  assign done_o = op_done;
  assign err_o  = op_err;

endmodule

//--- bench/flash_ctrl_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the read path top, bound into flash_ctrl_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module flash_ctrl_chk (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    cmd_valid_i,
  input flash_ctrl_pkg::cmd_op_e cmd_op_i,
  input logic                    cmd_rej_o,
  input logic                    busy_o,
  input logic                    done_o,
  input logic [3:0]              err_o
);

  // done only ends an operation that is still pending
  a_done_busy: assert property (@(posedge clk_i) disable iff (!rst_ni) done_o |-> busy_o)
    else $error("done_o high while busy_o is low");

  a_rej_op: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cmd_valid_i && cmd_op_i != flash_ctrl_pkg::OpRead) |=> cmd_rej_o)
    else $error("non-read command was not rejected");

  a_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(done_o) && !$isunknown(err_o))
    else $error("unknown value on done_o or err_o");

endmodule

bind flash_ctrl_top flash_ctrl_chk u_chk (.*);

//--- bench/flash_ctrl_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the flash read path, applies a command table and checks FIFO words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "flash_ctrl_cfg.svh"

module flash_ctrl_tb;

  localparam int NumRows = 12;

  typedef struct packed {
    flash_ctrl_pkg::cmd_op_e  op;
    logic [`FLASH_ADDR_W-1:0] addr;
    logic [`FLASH_LEN_W-1:0]  len;
    logic [3:0]               err;
    logic                     busy_cmd;
    logic [3:0]               gap;
  } row_t;

  // opcode, start word, words minus one, expected {oob,mp,rd,phy}, read while busy, pop gap
  row_t stim [NumRows] = '{
    '{flash_ctrl_pkg::OpRead,  16'd16,     12'd3,  4'b0000, 1'b0, 4'd1},
    '{flash_ctrl_pkg::OpRead,  16'd196,    12'd7,  4'b0010, 1'b0, 4'd2},
    '{flash_ctrl_pkg::OpRead,  16'd1100,   12'd3,  4'b1000, 1'b0, 4'd1},
    '{flash_ctrl_pkg::OpRead,  16'd956,    12'd5,  4'b0100, 1'b0, 4'd0},
    '{flash_ctrl_pkg::OpRead,  16'd1020,   12'd7,  4'b0100, 1'b0, 4'd1},
    '{flash_ctrl_pkg::OpProg,  16'd10,     12'd2,  4'b0000, 1'b0, 4'd0},
    '{flash_ctrl_pkg::OpErase, 16'd20,     12'd1,  4'b0000, 1'b0, 4'd0},
    '{flash_ctrl_pkg::OpNop,   16'd30,     12'd0,  4'b0000, 1'b0, 4'd0},
    '{flash_ctrl_pkg::OpRead,  16'd300,    12'd5,  4'b0000, 1'b1, 4'd1},
    '{flash_ctrl_pkg::OpRead,  16'd500,    12'd19, 4'b0000, 1'b0, 4'd6},
    '{flash_ctrl_pkg::OpRead,  16'd0,      12'd0,  4'b0000, 1'b0, 4'd0},
    '{flash_ctrl_pkg::OpRead,  16'hfffe,   12'd3,  4'b1000, 1'b0, 4'd2}
  };

  logic                     clk_i;
  logic                     rst_ni;
  logic                     cmd_valid_i;
  flash_ctrl_pkg::cmd_op_e  cmd_op_i;
  logic [`FLASH_ADDR_W-1:0] cmd_addr_i;
  logic [`FLASH_LEN_W-1:0]  cmd_len_i;
  logic                     pop_i;
  logic                     cmd_rej_o;
  logic                     busy_o;
  logic                     done_o;
  logic [3:0]               err_o;
  logic [`FLASH_ADDR_W-1:0] err_addr_o;
  logic [`FLASH_BUS_W-1:0]  rdata_o;
  logic                     empty_o;

  logic [31:0] got_q [$];
  int          err_cnt = 0;

  flash_ctrl_top dut0 (.*);

  always #50 clk_i = ~clk_i;

  function automatic longint watchdog_ns();
    longint words;
    words = 0;
    for (int i = 0; i < NumRows; i++) begin
      words += longint'(stim[i].len) + 1;
    end
    return words * (`FLASH_RD_LAT + 4) * 100 + NumRows * 4000 + 10000;
  endfunction

  // index of the first word that breaks an address rule, len+1 if none
  function automatic int first_bad(input row_t r);
    logic [`FLASH_ADDR_W:0] a;
    if (r.addr >= `FLASH_WORDS) return 0;
    for (int k = 0; k <= int'(r.len); k++) begin
      a = {1'b0, r.addr} + 17'(k);
      if ((a >= `FLASH_BAD_LO && a <= `FLASH_BAD_HI) || a >= `FLASH_PROT_BASE) return k;
    end
    return int'(r.len) + 1;
  endfunction

  function automatic logic [31:0] expected_word(input row_t r, input int k, input int fb);
    logic [`FLASH_ADDR_W-1:0] a;
    a = r.addr + `FLASH_ADDR_W'(k);
    if (k >= fb) return '1;
    return 32'(a) ^ flash_phy_pkg::DataKey;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0d ns: %s got %08h, expected %08h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic issue_cmd(input flash_ctrl_pkg::cmd_op_e op, input logic [15:0] addr,
                           input logic [11:0] len);
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_addr_i  = addr;
    cmd_len_i   = len;
  endtask

  // pop roughly once every gap+1 cycles while words are waiting
  task automatic pop_decide(input int gap);
    if (!empty_o && ($urandom % (gap + 1)) == 0) begin
      got_q.push_back(rdata_o);
      pop_i = 1'b1;
    end else begin
      pop_i = 1'b0;
    end
  endtask

  task automatic run_read(input int idx);
    row_t r;
    int   fb;
    int   cyc;
    bit   done_seen;
    r = stim[idx];
    fb = first_bad(r);
    cyc = 0;
    done_seen = 1'b0;
    got_q.delete();
    issue_cmd(r.op, r.addr, r.len);
    next_cycle();
    cmd_valid_i = 1'b0;
    check_eq(cmd_rej_o, 1'b0, "reject on accepted read");
    check_eq(busy_o, 1'b1, "busy after read");
    while (!done_seen) begin
      if (r.busy_cmd && cyc == 1) begin
        issue_cmd(flash_ctrl_pkg::OpRead, '0, '0);
      end else if (r.busy_cmd && cyc == 2) begin
        cmd_valid_i = 1'b0;
        check_eq(cmd_rej_o, 1'b1, "reject on read while busy");
      end
      if (done_o) begin
        done_seen = 1'b1;
        check_eq(err_o, r.err, "error bits");
      end
      pop_decide(int'(r.gap));
      next_cycle();
      cyc++;
    end
    // error address settles one cycle after an error on the last word
    if (r.err != '0) begin
      check_eq(err_addr_o, r.addr + 16'(fb), "error address");
    end
    while (!empty_o) begin
      pop_decide(0);
      next_cycle();
    end
    pop_i = 1'b0;
    check_eq(got_q.size(), int'(r.len) + 1, "word count");
    for (int k = 0; k <= int'(r.len); k++) begin
      check_eq(got_q[k], expected_word(r, k, fb), "read word");
    end
  endtask

  task automatic run_reject(input int idx);
    issue_cmd(stim[idx].op, stim[idx].addr, stim[idx].len);
    next_cycle();
    cmd_valid_i = 1'b0;
    check_eq(cmd_rej_o, 1'b1, "reject on bad opcode");
    repeat (4) begin
      next_cycle();
      check_eq(cmd_rej_o, 1'b0, "reject pulse length");
      check_eq(empty_o, 1'b1, "FIFO empty after reject");
      check_eq(busy_o, 1'b0, "idle after reject");
    end
  endtask

  initial begin
    #(watchdog_ns());
    $display("watchdog expired, the run did not finish in time");
    $display("sim failed");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(32'h16c7_e132));
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_op_i    = flash_ctrl_pkg::OpNop;
    cmd_addr_i  = '0;
    cmd_len_i   = '0;
    pop_i       = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();
    for (int i = 0; i < NumRows; i++) begin
      if (stim[i].op == flash_ctrl_pkg::OpRead) begin
        run_read(i);
      end else begin
        run_reject(i);
      end
      next_cycle();
    end
    if (err_cnt == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("sim failed");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- src.f
+incdir+source
source/flash_ctrl_pkg.sv
source/flash_phy_pkg.sv
source/flash_rd_if.sv
source/flash_cmd_decode.sv
source/flash_ctrl_rd.sv
source/flash_macro.sv
source/flash_rd_fifo.sv
source/flash_ctrl_top.sv
bench/flash_ctrl_chk.sv
bench/flash_ctrl_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = flash_ctrl_tb
FLIST    = src.f
OBJDIR   = obj_dir
LOG      = sim.log
FAIL_MSG = sim failed
PASS_MSG = sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test FAILED, no pass line"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)
